// File: verilog/exe_pkg.sv
package exe_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    // execution unit select
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_MEM
    } unit_e;

    typedef enum logic [3:0] {
        ADD, SUB,
        SLT, SLTU,
        AND, OR, XOR, NOR,
        SLL, SRL, SRA,
        LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } mem_width_e;

    // 12-bit decoded micro-op
    typedef struct packed {
        unit_e      unit;
        alu_op_e    alu_op;
        logic       src2_imm;
        logic       mul_high;
        logic       usign;      // unsigned mul or zero-extended load
        logic       mem_write;
        mem_width_e mem_width;
    } uop_t;

endpackage

// File: verilog/bypass_if.sv
`timescale 1ns/10ps

interface bypass_if;
    import exe_pkg::*;

    // exe1 level
    logic             en1_0, en1_1;
    logic [REG_W-1:0] rd1_0, rd1_1;
    logic [XLEN-1:0]  data1_0, data1_1;
    // out level
    logic             en2_0, en2_1;
    logic [REG_W-1:0] rd2_0, rd2_1;
    logic [XLEN-1:0]  data2_0, data2_1;
    // lane 0 load or multiply in exe1, result not ready yet
    logic             long1;
    logic [REG_W-1:0] long_rd1;

    modport source (output en1_0, rd1_0, data1_0, en1_1, rd1_1, data1_1,
                    en2_0, rd2_0, data2_0, en2_1, rd2_1, data2_1, long1, long_rd1);
    modport sink   (input  en1_0, rd1_0, data1_0, en1_1, rd1_1, data1_1,
                    en2_0, rd2_0, data2_0, en2_1, rd2_1, data2_1, long1, long_rd1);

endinterface

// File: verilog/alu.sv
`timescale 1ns/10ps

module alu (
    input  exe_pkg::alu_op_e           op,
    input  logic [exe_pkg::XLEN-1:0]   a,
    input  logic [exe_pkg::XLEN-1:0]   b,
    output logic [exe_pkg::XLEN-1:0]   result
);
    import exe_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLT: begin
                result = '0;
                result[0] = $signed(a) < $signed(b);
            end
            SLTU: begin
                result = '0;
                result[0] = a < b;
            end
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            NOR:     result = ~(a | b);
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            // immediate already shifted by decode
            LUI:     result = b;
            default: result = '0;
        endcase
    end

endmodule

// File: verilog/mul_unit.sv
`timescale 1ns/10ps

module mul_unit (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       hold,
    input  logic                       bubble,
    input  logic                       start,
    input  logic                       high,
    input  logic                       usign,
    input  logic [exe_pkg::XLEN-1:0]   a,
    input  logic [exe_pkg::XLEN-1:0]   b,
    output logic [exe_pkg::XLEN-1:0]   result
);
    import exe_pkg::*;

    logic               a_ext, b_ext;
    logic signed [16:0] a_lo, a_hi, b_lo, b_hi;
    logic signed [33:0] pp [4];
    logic signed [33:0] pp_q [4];
    logic               high_q;
    logic               valid_q;
    logic signed [65:0] prod;

    // exe0: split 33-bit operands into 17-bit halves
    assign a_ext = ~usign & a[31];
    assign b_ext = ~usign & b[31];
    assign a_lo  = {1'b0, a[15:0]};
    assign b_lo  = {1'b0, b[15:0]};
    assign a_hi  = {a_ext, a[31:16]};
    assign b_hi  = {b_ext, b[31:16]};

    assign pp[0] = a_lo * b_lo;
    assign pp[1] = a_lo * b_hi;
    assign pp[2] = a_hi * b_lo;
    assign pp[3] = a_hi * b_hi;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (!hold) begin
            valid_q <= start & ~bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && start) begin
            pp_q   <= pp;
            high_q <= high;
        end
    end

    // exe1: shift and add
    assign prod = (pp_q[3] <<< 32) + ((pp_q[1] + pp_q[2]) <<< 16) + pp_q[0];

    // zero when idle so lane 0 can merge by OR
    assign result = !valid_q ? '0 : (high_q ? prod[63:32] : prod[31:0]);

    // issue must gate a dependent multiply off during the bubble
    a_start_no_bubble: assert property (@(posedge clk) disable iff (!rstn)
        !(start && bubble));

endmodule

// File: verilog/mem_unit.sv
`timescale 1ns/10ps

module mem_unit (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       hold,
    input  logic                       bubble,
    input  logic                       start,
    input  exe_pkg::uop_t              uop,
    input  logic [exe_pkg::XLEN-1:0]   base,
    input  logic [exe_pkg::XLEN-1:0]   offset,
    input  logic [exe_pkg::XLEN-1:0]   store_data,
    output logic                       valid,
    output logic                       op,
    output logic [exe_pkg::XLEN-1:0]   addr,
    output logic [3:0]                 write_type,
    output logic [exe_pkg::XLEN-1:0]   w_data,
    input  logic                       data_valid,
    input  logic [exe_pkg::XLEN-1:0]   r_data,
    output logic                       busy,
    output logic [exe_pkg::XLEN-1:0]   load_data
);
    import exe_pkg::*;

    logic            occ_q;
    mem_width_e      width_q;
    logic            usign_q, write_q;
    logic [1:0]      lo_q;
    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] ext;

    // exe0 request
    assign addr  = base + offset;
    assign valid = start & ~hold;
    assign op    = uop.mem_write;

    always_comb begin
        case (uop.mem_width)
            BYTE: begin
                write_type = 4'b0001 << addr[1:0];
                w_data     = {4{store_data[7:0]}};
            end
            HALF: begin
                write_type = addr[1] ? 4'b1100 : 4'b0011;
                w_data     = {2{store_data[15:0]}};
            end
            default: begin
                write_type = 4'b1111;
                w_data     = store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            occ_q <= 1'b0;
        end else if (!hold) begin
            occ_q <= start & ~bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && start) begin
            width_q <= uop.mem_width;
            usign_q <= uop.usign;
            write_q <= uop.mem_write;
            lo_q    <= addr[1:0];
        end
    end

    // exe1 response alignment
    assign busy    = occ_q & ~data_valid;
    assign shifted = r_data >> {lo_q, 3'b000};

    always_comb begin
        case (width_q)
            BYTE:    ext = {{24{~usign_q & shifted[7]}}, shifted[7:0]};
            HALF:    ext = {{16{~usign_q & shifted[15]}}, shifted[15:0]};
            default: ext = r_data;
        endcase
    end

    assign load_data = (occ_q && !write_q) ? ext : '0;

    a_no_req_while_busy: assert property (@(posedge clk) disable iff (!rstn)
        busy |-> !valid);

endmodule

// File: verilog/operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass (
    bypass_if.sink                     byp,
    input  logic                       eu0_en,
    input  logic                       eu1_en,
    input  logic [exe_pkg::REG_W-1:0]  eu0_rj,
    input  logic [exe_pkg::REG_W-1:0]  eu0_rk,
    input  logic [exe_pkg::REG_W-1:0]  eu1_rj,
    input  logic [exe_pkg::REG_W-1:0]  eu1_rk,
    input  logic [exe_pkg::XLEN-1:0]   data_00,
    input  logic [exe_pkg::XLEN-1:0]   data_01,
    input  logic [exe_pkg::XLEN-1:0]   data_10,
    input  logic [exe_pkg::XLEN-1:0]   data_11,
    output logic [exe_pkg::XLEN-1:0]   eu0_src0,
    output logic [exe_pkg::XLEN-1:0]   eu0_src1,
    output logic [exe_pkg::XLEN-1:0]   eu1_src0,
    output logic [exe_pkg::XLEN-1:0]   eu1_src1,
    output logic                       hazard_stall
);
    import exe_pkg::*;

    // youngest writer wins, r0 never forwarded
    function automatic logic [XLEN-1:0] pick(input logic [REG_W-1:0] src,
                                             input logic [XLEN-1:0]  rf);
        if (src == '0)
            return rf;
        if (byp.en1_1 && byp.rd1_1 == src)
            return byp.data1_1;
        if (byp.en1_0 && byp.rd1_0 == src)
            return byp.data1_0;
        if (byp.en2_1 && byp.rd2_1 == src)
            return byp.data2_1;
        if (byp.en2_0 && byp.rd2_0 == src)
            return byp.data2_0;
        return rf;
    endfunction

    function automatic logic long_hit(input logic [REG_W-1:0] src);
        return byp.long1 && src != '0 && src == byp.long_rd1;
    endfunction

    always_comb begin
        eu0_src0 = pick(eu0_rj, data_00);
        eu0_src1 = pick(eu0_rk, data_01);
        eu1_src0 = pick(eu1_rj, data_10);
        eu1_src1 = pick(eu1_rk, data_11);
        // load/mul result not ready until it reaches the out level
        hazard_stall = (eu0_en && (long_hit(eu0_rj) || long_hit(eu0_rk)))
                    || (eu1_en && (long_hit(eu1_rj) || long_hit(eu1_rk)));
    end

endmodule

// File: verilog/exe.sv
`timescale 1ns/10ps

module exe (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       eu0_en,
    input  exe_pkg::uop_t              eu0_uop,
    input  logic [exe_pkg::REG_W-1:0]  eu0_rd,
    input  logic [exe_pkg::REG_W-1:0]  eu0_rj,
    input  logic [exe_pkg::REG_W-1:0]  eu0_rk,
    input  logic [exe_pkg::XLEN-1:0]   eu0_imm,
    input  logic [exe_pkg::XLEN-1:0]   data_00,
    input  logic [exe_pkg::XLEN-1:0]   data_01,
    input  logic                       eu1_en,
    input  exe_pkg::uop_t              eu1_uop,
    input  logic [exe_pkg::REG_W-1:0]  eu1_rd,
    input  logic [exe_pkg::REG_W-1:0]  eu1_rj,
    input  logic [exe_pkg::REG_W-1:0]  eu1_rk,
    input  logic [exe_pkg::XLEN-1:0]   eu1_imm,
    input  logic [exe_pkg::XLEN-1:0]   data_10,
    input  logic [exe_pkg::XLEN-1:0]   data_11,
    output logic                       valid,
    output logic                       op,
    output logic [exe_pkg::XLEN-1:0]   addr,
    output logic [3:0]                 write_type,
    output logic [exe_pkg::XLEN-1:0]   w_data,
    input  logic                       data_valid,
    input  logic [exe_pkg::XLEN-1:0]   r_data,
    output logic                       en_out0,
    output logic [exe_pkg::REG_W-1:0]  addr_out0,
    output logic [exe_pkg::XLEN-1:0]   data_out0,
    output logic                       en_out1,
    output logic [exe_pkg::REG_W-1:0]  addr_out1,
    output logic [exe_pkg::XLEN-1:0]   data_out1,
    output logic                       stall
);
    import exe_pkg::*;

    logic [XLEN-1:0]  eu0_src0, eu0_src1, eu1_src0, eu1_src1;
    logic [XLEN-1:0]  alu0_b, alu1_b, alu0_res, alu1_res;
    logic [XLEN-1:0]  mul_result, load_data;
    logic             hazard_stall, cache_stall, bubble;
    logic             mul_start, mem_start;
    // exe1 level
    logic             alu_en1_0, alu_en1_1, long_en1;
    logic [REG_W-1:0] rd1_0, rd1_1;
    logic [XLEN-1:0]  data1_0, data1_1;

    bypass_if byp ();

    assign stall  = hazard_stall | cache_stall;
    assign bubble = hazard_stall & ~cache_stall;

    assign mul_start = eu0_en && eu0_uop.unit == UNIT_MUL && !hazard_stall;
    assign mem_start = eu0_en && eu0_uop.unit == UNIT_MEM && !hazard_stall;

    assign alu0_b = eu0_uop.src2_imm ? eu0_imm : eu0_src1;
    assign alu1_b = eu1_uop.src2_imm ? eu1_imm : eu1_src1;

    alu u_alu0 (.op(eu0_uop.alu_op), .a(eu0_src0), .b(alu0_b), .result(alu0_res));
    alu u_alu1 (.op(eu1_uop.alu_op), .a(eu1_src0), .b(alu1_b), .result(alu1_res));

    mul_unit u_mul (
        .clk(clk), .rstn(rstn), .hold(cache_stall), .bubble(bubble),
        .start(mul_start), .high(eu0_uop.mul_high), .usign(eu0_uop.usign),
        .a(eu0_src0), .b(eu0_src1), .result(mul_result)
    );

    mem_unit u_mem (
        .clk(clk), .rstn(rstn), .hold(cache_stall), .bubble(bubble),
        .start(mem_start), .uop(eu0_uop), .base(eu0_src0), .offset(eu0_imm),
        .store_data(eu0_src1), .valid(valid), .op(op), .addr(addr),
        .write_type(write_type), .w_data(w_data), .data_valid(data_valid),
        .r_data(r_data), .busy(cache_stall), .load_data(load_data)
    );

    operand_bypass u_bypass (
        .byp(byp), .eu0_en(eu0_en), .eu1_en(eu1_en),
        .eu0_rj(eu0_rj), .eu0_rk(eu0_rk), .eu1_rj(eu1_rj), .eu1_rk(eu1_rk),
        .data_00(data_00), .data_01(data_01), .data_10(data_10), .data_11(data_11),
        .eu0_src0(eu0_src0), .eu0_src1(eu0_src1),
        .eu1_src0(eu1_src0), .eu1_src1(eu1_src1),
        .hazard_stall(hazard_stall)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            alu_en1_0 <= 1'b0;
            alu_en1_1 <= 1'b0;
            long_en1  <= 1'b0;
        end else if (!cache_stall) begin
            alu_en1_0 <= eu0_en && eu0_uop.unit == UNIT_ALU && !hazard_stall;
            alu_en1_1 <= eu1_en && !hazard_stall;
            // stores leave no writeback
            long_en1  <= (mul_start || (mem_start && !eu0_uop.mem_write));
        end
    end

    always_ff @(posedge clk) begin
        if (!cache_stall) begin
            rd1_0   <= eu0_rd;
            rd1_1   <= eu1_rd;
            data1_0 <= alu0_res;
            data1_1 <= alu1_res;
        end
    end

    // out level, en is a single pulse per item
    always_ff @(posedge clk) begin
        if (!rstn || cache_stall) begin
            en_out0 <= 1'b0;
            en_out1 <= 1'b0;
        end else begin
            en_out0 <= alu_en1_0 | long_en1;
            en_out1 <= alu_en1_1;
        end
    end

    always_ff @(posedge clk) begin
        if (!cache_stall) begin
            addr_out0 <= rd1_0;
            addr_out1 <= rd1_1;
            data_out0 <= alu_en1_0 ? data1_0 : (mul_result | load_data);
            data_out1 <= data1_1;
        end
    end

    assign byp.en1_0    = alu_en1_0;
    assign byp.rd1_0    = rd1_0;
    assign byp.data1_0  = data1_0;
    assign byp.en1_1    = alu_en1_1;
    assign byp.rd1_1    = rd1_1;
    assign byp.data1_1  = data1_1;
    assign byp.en2_0    = en_out0;
    assign byp.rd2_0    = addr_out0;
    assign byp.data2_0  = data_out0;
    assign byp.en2_1    = en_out1;
    assign byp.rd2_1    = addr_out1;
    assign byp.data2_1  = data_out1;
    assign byp.long1    = long_en1;
    assign byp.long_rd1 = rd1_0;

    // lane 1 has only an ALU
    a_lane1_alu_only: assert property (@(posedge clk) disable iff (!rstn)
        eu1_en |-> eu1_uop.unit == UNIT_ALU);

endmodule

// File: testbench/exe_checker.sv
`timescale 1ns/10ps

module exe_checker (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      eu0_en,
    input  exe_pkg::uop_t             eu0_uop,
    input  logic [exe_pkg::REG_W-1:0] eu0_rd,
    input  logic [exe_pkg::REG_W-1:0] eu0_rj,
    input  logic [exe_pkg::REG_W-1:0] eu0_rk,
    input  logic [exe_pkg::XLEN-1:0]  eu0_imm,
    input  logic                      eu1_en,
    input  exe_pkg::uop_t             eu1_uop,
    input  logic [exe_pkg::REG_W-1:0] eu1_rd,
    input  logic [exe_pkg::REG_W-1:0] eu1_rj,
    input  logic [exe_pkg::REG_W-1:0] eu1_rk,
    input  logic [exe_pkg::XLEN-1:0]  eu1_imm,
    input  logic                      valid,
    input  logic                      op,
    input  logic [exe_pkg::XLEN-1:0]  addr,
    input  logic [3:0]                write_type,
    input  logic [exe_pkg::XLEN-1:0]  w_data,
    input  logic                      stall,
    input  logic                      en_out0,
    input  logic [exe_pkg::REG_W-1:0] addr_out0,
    input  logic [exe_pkg::XLEN-1:0]  data_out0,
    input  logic                      en_out1,
    input  logic [exe_pkg::REG_W-1:0] addr_out1,
    input  logic [exe_pkg::XLEN-1:0]  data_out1,
    output int                        errors,
    output int                        pending,
    output int                        pushes,
    output int                        pops
);
    import exe_pkg::*;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        int          cyc;
        int          stalls;
    } wb_t;

    logic [31:0] shadow_rf [32];
    logic [31:0] shadow_mem [256];
    wb_t         q0 [$];
    wb_t         q1 [$];
    int          cyc;
    int          stall_total;

    initial begin
        for (int i = 0; i < 32; i++)
            shadow_rf[i] = '0;
        // same fill as the cache model
        for (int i = 0; i < 256; i++)
            shadow_mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        errors  = 0;
        pending = 0;
        pushes  = 0;
        pops    = 0;
    end

    function automatic logic [31:0] expected_result(input uop_t u, input logic [31:0] a,
                                                    input logic [31:0] b,
                                                    input logic [31:0] imm);
        logic [31:0] op2;
        logic [63:0] p;
        logic [31:0] ea;
        logic [31:0] w;
        op2 = u.src2_imm ? imm : b;
        if (u.unit == UNIT_MUL) begin
            if (u.usign)
                p = {32'b0, a} * {32'b0, b};
            else
                p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            return u.mul_high ? p[63:32] : p[31:0];
        end
        if (u.unit == UNIT_MEM) begin
            ea = a + imm;
            w  = shadow_mem[ea[9:2]] >> (8 * ea[1:0]);
            if (u.mem_width == BYTE)
                return u.usign ? {24'b0, w[7:0]} : {{24{w[7]}}, w[7:0]};
            if (u.mem_width == HALF)
                return u.usign ? {16'b0, w[15:0]} : {{16{w[15]}}, w[15:0]};
            return shadow_mem[ea[9:2]];
        end
        case (u.alu_op)
            ADD:     return a + op2;
            SUB:     return a - op2;
            SLT:     return {31'b0, $signed(a) < $signed(op2)};
            SLTU:    return {31'b0, a < op2};
            AND:     return a & op2;
            OR:      return a | op2;
            XOR:     return a ^ op2;
            NOR:     return ~(a | op2);
            SLL:     return a << op2[4:0];
            SRL:     return a >> op2[4:0];
            SRA:     return $signed(a) >>> op2[4:0];
            LUI:     return op2;
            default: return '0;
        endcase
    endfunction

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("Error %0t %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    // request fields are visible during the accepting cycle
    task automatic check_request(input uop_t u, input logic [31:0] a, input logic [31:0] b,
                                 input logic [31:0] imm);
        logic [31:0] ea;
        logic [3:0]  be;
        logic [31:0] wd;
        ea = a + imm;
        case (u.mem_width)
            BYTE: begin
                be = 4'b0001 << ea[1:0];
                wd = {4{b[7:0]}};
            end
            HALF: begin
                be = ea[1] ? 4'b1100 : 4'b0011;
                wd = {2{b[15:0]}};
            end
            default: begin
                be = 4'b1111;
                wd = b;
            end
        endcase
        if (!valid)
            report("valid", 1, valid);
        if (op !== u.mem_write)
            report("op", u.mem_write, op);
        if (addr !== ea)
            report("addr", ea, addr);
        if (write_type !== be)
            report("write_type", be, write_type);
        if (u.mem_write && w_data !== wd)
            report("w_data", wd, w_data);
        if (u.mem_write) begin
            for (int i = 0; i < 4; i++)
                if (be[i])
                    shadow_mem[ea[9:2]][8*i +: 8] = wd[8*i +: 8];
        end
    endtask

    task automatic accept(input int lane, input uop_t u, input logic [4:0] rd,
                          input logic [4:0] rj, input logic [4:0] rk, input logic [31:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        wb_t         e;
        a = shadow_rf[rj];
        b = shadow_rf[rk];
        if (u.unit == UNIT_MEM)
            check_request(u, a, b, imm);
        if (u.unit == UNIT_MEM && u.mem_write)
            return;
        e.rd     = rd;
        e.data   = expected_result(u, a, b, imm);
        e.cyc    = cyc;
        e.stalls = stall_total;
        if (rd != 0)
            shadow_rf[rd] = e.data;
        if (lane == 0)
            q0.push_back(e);
        else
            q1.push_back(e);
        pushes++;
    endtask

    task automatic retire(input int lane, input logic [4:0] rd, input logic [31:0] data);
        wb_t e;
        pops++;
        if ((lane == 0 && q0.size() == 0) || (lane == 1 && q1.size() == 0)) begin
            $display("lane %0d wrote back at %0t with nothing pending", lane, $time);
            errors++;
            return;
        end
        e = (lane == 0) ? q0.pop_front() : q1.pop_front();
        if (rd !== e.rd)
            report(lane == 0 ? "addr_out0" : "addr_out1", e.rd, rd);
        if (data !== e.data)
            report(lane == 0 ? "data_out0" : "data_out1", e.data, data);
        // out register loads one edge after acceptance, seen at the next
        if (stall_total == e.stalls && cyc - e.cyc != 2)
            report(lane == 0 ? "latency0" : "latency1", 2, cyc - e.cyc);
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            cyc         = 0;
            stall_total = 0;
        end else begin
            if (en_out0)
                retire(0, addr_out0, data_out0);
            if (en_out1)
                retire(1, addr_out1, data_out1);
            // request only for an accepted memory op
            if (valid && !(eu0_en && eu0_uop.unit == UNIT_MEM && !stall))
                report("valid", 0, valid);
            if (eu0_en && !stall)
                accept(0, eu0_uop, eu0_rd, eu0_rj, eu0_rk, eu0_imm);
            if (eu1_en && !stall)
                accept(1, eu1_uop, eu1_rd, eu1_rj, eu1_rk, eu1_imm);
            if (stall)
                stall_total++;
            cyc++;
            pending = q0.size() + q1.size();
        end
    end

endmodule

// File: testbench/exe_tb.sv
`timescale 1ns/10ps

module exe_tb;
    import exe_pkg::*;

    logic        clk, rstn;
    logic        eu0_en, eu1_en;
    uop_t        eu0_uop, eu1_uop;
    logic [4:0]  eu0_rd, eu0_rj, eu0_rk, eu1_rd, eu1_rj, eu1_rk;
    logic [31:0] eu0_imm, eu1_imm, data_00, data_01, data_10, data_11;
    logic        valid, op, data_valid, stall;
    logic [31:0] addr, w_data, r_data;
    logic [3:0]  write_type;
    logic        en_out0, en_out1;
    logic [4:0]  addr_out0, addr_out1;
    logic [31:0] data_out0, data_out1;
    int          errors, pending, pushes, pops;

    logic [31:0] rf [32];
    logic [31:0] mem [256];
    integer      seed;
    logic        random_delay;
    int          stall_cycles, tb_errors, test_count, failed_tests;
    int          err_mark, stall_mark;

    exe DUT (.*);

    exe_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // register file model, written from the writeback ports
    always @(posedge clk) begin
        if (rstn && en_out0 && addr_out0 != 0)
            rf[addr_out0] <= data_out0;
        if (rstn && en_out1 && addr_out1 != 0)
            rf[addr_out1] <= data_out1;
    end

    always @(negedge clk) begin
        if (rstn && stall)
            stall_cycles++;
    end

    // cache model, one access at a time
    initial begin
        logic        req, wr;
        logic [31:0] a, wd;
        logic [3:0]  be;
        int          d;
        forever begin
            @(posedge clk);
            req = rstn && valid;
            wr  = op;
            a   = addr;
            be  = write_type;
            wd  = w_data;
            #2;
            data_valid = 1'b0;
            if (req) begin
                if (wr) begin
                    for (int i = 0; i < 4; i++)
                        if (be[i])
                            mem[a[9:2]][8*i +: 8] = wd[8*i +: 8];
                end
                d = random_delay ? {$random(seed)} % 4 : 0;
                repeat (d) begin
                    @(posedge clk);
                    #2;
                end
                data_valid = 1'b1;
                r_data     = mem[a[9:2]];
            end
        end
    end

    function automatic uop_t build_uop(input unit_e un, input alu_op_e o, input logic imm,
                                       input logic hi, input logic us, input logic wr,
                                       input mem_width_e w);
        uop_t u;
        u.unit      = un;
        u.alu_op    = o;
        u.src2_imm  = imm;
        u.mul_high  = hi;
        u.usign     = us;
        u.mem_write = wr;
        u.mem_width = w;
        return u;
    endfunction

    function automatic uop_t au(input alu_op_e o, input logic imm);
        return build_uop(UNIT_ALU, o, imm, 1'b0, 1'b0, 1'b0, WORD);
    endfunction

    function automatic uop_t mu(input logic hi, input logic us);
        return build_uop(UNIT_MUL, ADD, 1'b0, hi, us, 1'b0, WORD);
    endfunction

    function automatic uop_t memu(input logic wr, input mem_width_e w, input logic us);
        return build_uop(UNIT_MEM, ADD, 1'b1, 1'b0, us, wr, w);
    endfunction

    task automatic finish_run();
        $display("tests %0d, failed %0d, writebacks %0d of %0d, errors %0d",
                 test_count, failed_tests, pops, pushes, errors + tb_errors);
        if (errors == 0 && tb_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    endtask

    task automatic drive_operands();
        data_00 = rf[eu0_rj];
        data_01 = rf[eu0_rk];
        data_10 = rf[eu1_rj];
        data_11 = rf[eu1_rk];
    endtask

    // called at a rising edge, returns at the accepting edge
    task automatic issue_pair(input logic e0, input uop_t u0, input logic [4:0] rd0,
                              input logic [4:0] rj0, input logic [4:0] rk0,
                              input logic [31:0] imm0, input logic e1, input uop_t u1,
                              input logic [4:0] rd1, input logic [4:0] rj1,
                              input logic [4:0] rk1, input logic [31:0] imm1);
        logic s;
        int   t;
        #2;
        eu0_en  = e0;
        eu0_uop = u0;
        eu0_rd  = rd0;
        eu0_rj  = rj0;
        eu0_rk  = rk0;
        eu0_imm = imm0;
        eu1_en  = e1;
        eu1_uop = u1;
        eu1_rd  = rd1;
        eu1_rj  = rj1;
        eu1_rk  = rk1;
        eu1_imm = imm1;
        t = 0;
        forever begin
            drive_operands();
            @(negedge clk);
            s = stall;
            @(posedge clk);
            if (!s)
                break;
            t++;
            if (t > 200) begin
                $display("timeout: stall stayed high for 200 cycles");
                tb_errors++;
                finish_run();
            end
            #2;
        end
    endtask

    task automatic drain();
        int t;
        issue_pair(0, au(ADD, 0), 0, 0, 0, 0, 0, au(ADD, 0), 0, 0, 0, 0);
        t = 0;
        while (pending != 0) begin
            @(posedge clk);
            t++;
            if (t > 200) begin
                $display("timeout: writebacks still pending after 200 cycles");
                tb_errors++;
                finish_run();
            end
        end
    endtask

    task automatic start_test();
        err_mark   = errors;
        stall_mark = stall_cycles;
    endtask

    task automatic end_test(input string name, input int exp_stalls);
        int e;
        drain();
        e = errors - err_mark;
        if (exp_stalls >= 0 && stall_cycles - stall_mark != exp_stalls) begin
            $display("%s saw %0d stall cycles instead of %0d", name,
                     stall_cycles - stall_mark, exp_stalls);
            tb_errors++;
            e++;
        end
        test_count++;
        if (e != 0)
            failed_tests++;
        $display("test %0d %s: %0d errors", test_count, name, e);
    endtask

    initial begin
        logic [4:0]  rd0, rj0, rk0, rj1, rk1;
        mem_width_e  w;
        logic [31:0] imm;
        uop_t        u0;
        seed         = 34;
        random_delay = 1'b0;
        stall_cycles = 0;
        tb_errors    = 0;
        test_count   = 0;
        failed_tests = 0;
        rstn = 1'b0;
        eu0_en = 1'b0;
        eu1_en = 1'b0;
        eu0_uop = '0;
        eu1_uop = '0;
        {eu0_rd, eu0_rj, eu0_rk, eu1_rd, eu1_rj, eu1_rk} = '0;
        {eu0_imm, eu1_imm, data_00, data_01, data_10, data_11} = '0;
        data_valid = 1'b0;
        r_data = '0;
        for (int i = 0; i < 32; i++)
            rf[i] = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        repeat (16) @(posedge clk);
        #2 rstn = 1'b1;
        @(posedge clk);

        start_test();
        issue_pair(1, au(ADD, 1), 1, 0, 0, 32'h8000_1234, 1, au(ADD, 1), 2, 0, 0, 32'h13);
        issue_pair(1, au(ADD, 1), 3, 0, 0, 32'hffff_ff85, 1, au(ADD, 1), 4, 0, 0, 32'h7);
        issue_pair(1, au(ADD, 1), 5, 0, 0, 32'h7fff_0001, 1, au(ADD, 1), 6, 0, 0, 32'h9abc);
        for (int k = 0; k < 12; k++) begin
            for (int s = 0; s < 2; s++)
                issue_pair(1, au(alu_op_e'(k), s), 8, 1, 2, 32'h0000_0004,
                           1, au(alu_op_e'(k), s), 9, 3, 4, 32'hffff_f00d);
        end
        end_test("alu ops", 0);

        start_test();
        for (int k = 0; k < 4; k++) begin
            issue_pair(1, mu(k[1], k[0]), 10, 1, 3, 0, 1, au(XOR, 0), 11, 5, 6, 0);
            issue_pair(1, mu(k[1], k[0]), 10, 5, 3, 0, 1, au(NOR, 0), 11, 1, 6, 0);
        end
        end_test("multiply", 0);

        start_test();
        issue_pair(1, memu(1, WORD, 0), 0, 0, 1, 32'h40, 0, au(ADD, 0), 0, 0, 0, 0);
        issue_pair(1, memu(1, HALF, 0), 0, 0, 6, 32'h46, 1, au(ADD, 1), 7, 0, 0, 1);
        issue_pair(1, memu(1, BYTE, 0), 0, 0, 3, 32'h45, 0, au(ADD, 0), 0, 0, 0, 0);
        for (int k = 0; k < 4; k++) begin
            issue_pair(1, memu(0, BYTE, 0), 12, 0, 0, 32'h44 + k, 0, au(ADD, 0), 0, 0, 0, 0);
            issue_pair(1, memu(0, BYTE, 1), 12, 0, 0, 32'h44 + k, 0, au(ADD, 0), 0, 0, 0, 0);
        end
        for (int k = 0; k < 2; k++) begin
            issue_pair(1, memu(0, HALF, k), 12, 0, 0, 32'h44, 0, au(ADD, 0), 0, 0, 0, 0);
            issue_pair(1, memu(0, HALF, k), 12, 0, 0, 32'h46, 0, au(ADD, 0), 0, 0, 0, 0);
            issue_pair(1, memu(0, WORD, 0), 12, 0, 0, 32'h40 + 4 * k, 0, au(ADD, 0), 0, 0, 0, 0);
        end
        end_test("store and load", 0);

        start_test();
        for (int k = 0; k < 6; k++)
            issue_pair(1, au(ADD, 0), 13, 13, 14, 0, 1, au(ADD, 1), 14, 14, 0, 5);
        issue_pair(1, au(ADD, 1), 15, 1, 0, 0, 1, au(ADD, 1), 16, 2, 0, 0);
        issue_pair(1, au(SUB, 0), 17, 13, 14, 0, 1, au(OR, 0), 18, 15, 16, 0);
        end_test("forwarding chains", 0);

        start_test();
        issue_pair(1, memu(0, WORD, 0), 19, 0, 0, 32'h40, 0, au(ADD, 0), 0, 0, 0, 0);
        issue_pair(1, au(ADD, 0), 20, 19, 1, 0, 1, au(ADD, 1), 21, 19, 0, 1);
        issue_pair(1, mu(0, 0), 22, 1, 3, 0, 0, au(ADD, 0), 0, 0, 0, 0);
        issue_pair(0, au(ADD, 0), 0, 0, 0, 0, 1, au(SUB, 0), 23, 22, 2, 0);
        end_test("load and multiply use", 2);

        start_test();
        random_delay = 1'b1;
        for (int k = 0; k < 150; k++) begin
            rd0 = 1 + {$random(seed)} % 7;
            rj0 = {$random(seed)} % 8;
            rk0 = {$random(seed)} % 8;
            rj1 = {$random(seed)} % 8;
            rk1 = {$random(seed)} % 8;
            // lane 1 must not read its partner's result
            if (rj1 == rd0)
                rj1 = 0;
            if (rk1 == rd0)
                rk1 = 0;
            imm = $random(seed);
            case ({$random(seed)} % 3)
                0: u0 = au(alu_op_e'({$random(seed)} % 12), imm[0]);
                1: u0 = mu(imm[1], imm[2]);
                default: begin
                    w   = mem_width_e'({$random(seed)} % 3);
                    u0  = memu(imm[3], w, imm[4]);
                    rj0 = 0;
                    imm = {$random(seed)} % 1024;
                    imm = (w == WORD) ? imm & ~32'h3 : (w == HALF) ? imm & ~32'h1 : imm;
                end
            endcase
            issue_pair(1, u0, rd0, rj0, rk0, imm,
                       {$random(seed)} % 4 != 0, au(alu_op_e'({$random(seed)} % 12), imm[5]),
                       1 + {$random(seed)} % 7, rj1, rk1, $random(seed));
        end
        end_test("random cache delay", -1);
        if (pushes != pops) begin
            $display("%0d writebacks expected but %0d seen", pushes, pops);
            tb_errors++;
        end
        finish_run();
    end

endmodule

// File: flist.f
verilog/exe_pkg.sv
verilog/bypass_if.sv
verilog/alu.sv
verilog/mul_unit.sv
verilog/mem_unit.sv
verilog/operand_bypass.sv
verilog/exe.sv
testbench/exe_checker.sv
testbench/exe_tb.sv

// File: Bender.yml
package:
  name: exe

sources:
  - files:
      - verilog/exe_pkg.sv
      - verilog/bypass_if.sv
      - verilog/alu.sv
      - verilog/mul_unit.sv
      - verilog/mem_unit.sv
      - verilog/operand_bypass.sv
      - verilog/exe.sv
  - target: simulation
    files:
      - testbench/exe_checker.sv
      - testbench/exe_tb.sv
